/* src/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int addr_w = 64;
    localparam int data_w = 64;

    // on-chip ram, 32-bit words
    localparam logic [addr_w-1:0] ram_base = 64'h2000;
    localparam int ram_words = 1024;
    localparam int ram_aw = $clog2(ram_words);

    // single-register peripherals
    localparam logic [addr_w-1:0] key_addr = 64'h1_0000;
    localparam logic [addr_w-1:0] uart_addr = 64'h1_0008;
    localparam logic [addr_w-1:0] sdc_addr_addr = 64'h1_0010;
    localparam logic [addr_w-1:0] sdc_read_addr = 64'h1_0018;
    localparam logic [addr_w-1:0] sdc_ready_addr = 64'h1_0020;
    localparam logic [addr_w-1:0] sdc_avail_addr = 64'h1_0028;

    // sd sector window
    localparam logic [addr_w-1:0] sdc_buf_base = 64'h1_1000;
    localparam int sector_bytes = 512;
    localparam int sec_aw = $clog2(sector_bytes);
    // fill index at which a stale sector stops being reported
    localparam int avail_clear_idx = 10;

    // load size codes, stores reuse 0..3 as sb sh sw sd
    typedef enum logic [2:0] {
        lb = 3'd0,
        lh = 3'd1,
        lw = 3'd2,
        ld = 3'd3,
        lbu = 3'd4,
        lhu = 3'd5,
        lwu = 3'd6
    } ls_type_e;

    // decoded target of an access
    typedef enum logic [3:0] {
        ram,
        key,
        uart,
        sdc_addr,
        sdc_read,
        sdc_ready,
        sdc_avail,
        sdc_buf,
        none
    } region_e;

    // core request, held from strobe until done
    typedef struct packed {
        logic [addr_w-1:0] address;
        logic [data_w-1:0] wdata;
        ls_type_e ls_type;
    } bus_req_t;

    // one word port into the ram
    typedef struct packed {
        logic [ram_aw-1:0] index;
        logic [31:0] wdata;
        logic [3:0] be;
        logic we;
    } ram_port_t;

endpackage

`default_nettype wire

/* src/word_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module word_ram (
    input wire CLOCK_50,
    input wire soc_pkg::ram_port_t port,
    output logic [31:0] rdata
);

    logic [31:0] mem [soc_pkg::ram_words];

    // byte-lane writes, read registered one cycle
    always_ff @(posedge CLOCK_50) begin
        if (port.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (port.be[lane]) begin
                    mem[port.index][8*lane +: 8] <= port.wdata[8*lane +: 8];
                end
            end
        end
        // old word on a same-cycle write
        rdata <= mem[port.index];
    end

endmodule

`default_nettype wire

/* src/sd_sector_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_sector_buffer (
    input wire CLOCK_50,
    input wire KEY0,
    input wire [7:0] sd_dout,
    input wire sd_byte_available,
    input wire [soc_pkg::sec_aw-1:0] index,
    output logic [7:0] byte_out,
    output logic available
);

    logic [7:0] mem [soc_pkg::sector_bytes];
    // one extra bit so a full sector is visible
    logic [soc_pkg::sec_aw:0] fill;
    logic strobe_d;
    logic byte_edge;

    // one byte per rise of the strobe
    assign byte_edge = sd_byte_available && !strobe_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            strobe_d <= 1'b0;
            fill <= '0;
            available <= 1'b0;
        end else begin
            strobe_d <= sd_byte_available;
            if (byte_edge) begin
                fill <= fill + 1'b1;
            end
            // next sector underway, old data is stale
            if (fill == (soc_pkg::sec_aw + 1)'(soc_pkg::avail_clear_idx)) begin
                available <= 1'b0;
            end
            // full sector, wrap and flag
            if (fill == (soc_pkg::sec_aw + 1)'(soc_pkg::sector_bytes)) begin
                fill <= '0;
                available <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_edge) begin
            mem[fill[soc_pkg::sec_aw-1:0]] <= sd_dout;
        end
    end

    // combinational read for the bus
    assign byte_out = mem[index];

endmodule

`default_nettype wire

/* src/key_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module key_irq (
    input wire CLOCK_50,
    input wire KEY0,
    input wire [7:0] ascii,
    input wire key_pressed,
    input wire irq_ack,
    output logic [7:0] key_code,
    output logic [3:0] irq_vector,
    output logic irq_led
);

    logic pressed_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pressed_d <= 1'b0;
            key_code <= 8'd0;
            irq_vector <= 4'd0;
            irq_led <= 1'b0;
        end else begin
            pressed_d <= key_pressed;
            // code taken on the press edge only
            if (key_pressed && !pressed_d) begin
                key_code <= ascii;
            end
            // level sensitive, held until acked
            if (key_pressed && ascii != 8'd0) begin
                irq_vector <= 4'd1;
                irq_led <= 1'b1;
            end
            // ack wins over a held key
            if (irq_vector != 4'd0 && irq_ack) begin
                irq_vector <= 4'd0;
                irq_led <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/mmio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_regs (
    input wire CLOCK_50,
    input wire KEY0,
    input wire sdc_addr_we,
    input wire sdc_read_we,
    input wire uart_we,
    input wire [31:0] wdata,
    output logic [31:0] sd_addr,
    output logic sd_rd_start,
    output logic [31:0] uart_data,
    output logic uart_write
);

    // strobes are single cycle, so the pulses are too
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_addr <= 32'd0;
            sd_rd_start <= 1'b0;
            uart_write <= 1'b0;
        end else begin
            sd_rd_start <= sdc_read_we;
            uart_write <= uart_we;
            if (sdc_addr_we) begin
                sd_addr <= wdata;
            end
        end
    end

    // console byte rides alongside the pulse
    always_ff @(posedge CLOCK_50) begin
        if (uart_we) begin
            uart_data <= wdata;
        end
    end

endmodule

`default_nettype wire

/* src/bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_controller (
    input wire CLOCK_50,
    input wire KEY0,
    input wire soc_pkg::bus_req_t req,
    input wire read_en,
    input wire write_en,
    output logic [soc_pkg::data_w-1:0] read_data,
    output logic read_done,
    output logic write_done,
    output soc_pkg::ram_port_t ram_port,
    input wire [31:0] ram_rdata,
    output logic [soc_pkg::sec_aw-1:0] sdbuf_index,
    input wire [7:0] sdbuf_byte,
    input wire sdbuf_avail,
    input wire [7:0] key_code,
    input wire sd_ready,
    output logic sdc_addr_we,
    output logic sdc_read_we,
    output logic uart_we,
    output logic [31:0] mmio_wdata
);

    typedef enum logic [1:0] {st_idle, st_first, st_second} state_e;

    state_e state;
    // access kind, captured at the strobe
    logic is_read;
    // last cycle before done rises
    logic finish;
    soc_pkg::region_e region;
    logic [soc_pkg::addr_w-1:0] ram_off;
    logic [soc_pkg::addr_w-1:0] buf_off;
    logic [soc_pkg::ram_aw-1:0] word_idx;
    logic [1:0] offset;
    logic is_double;
    logic [soc_pkg::data_w-1:0] src_data;

    // address decode, request is stable for the whole access
    always_comb begin
        if (req.address >= soc_pkg::ram_base &&
            req.address < soc_pkg::ram_base + 64'(4 * soc_pkg::ram_words)) begin
            region = soc_pkg::ram;
        end else if (req.address == soc_pkg::key_addr) begin
            region = soc_pkg::key;
        end else if (req.address == soc_pkg::uart_addr) begin
            region = soc_pkg::uart;
        end else if (req.address == soc_pkg::sdc_addr_addr) begin
            region = soc_pkg::sdc_addr;
        end else if (req.address == soc_pkg::sdc_read_addr) begin
            region = soc_pkg::sdc_read;
        end else if (req.address == soc_pkg::sdc_ready_addr) begin
            region = soc_pkg::sdc_ready;
        end else if (req.address == soc_pkg::sdc_avail_addr) begin
            region = soc_pkg::sdc_avail;
        end else if (req.address >= soc_pkg::sdc_buf_base &&
                     req.address < soc_pkg::sdc_buf_base + 64'(soc_pkg::sector_bytes)) begin
            region = soc_pkg::sdc_buf;
        end else begin
            region = soc_pkg::none;
        end
    end

    assign ram_off = req.address - soc_pkg::ram_base;
    assign buf_off = req.address - soc_pkg::sdc_buf_base;
    assign word_idx = ram_off[soc_pkg::ram_aw+1:2];
    assign offset = req.address[1:0];
    assign is_double = (req.ls_type == soc_pkg::ld);
    assign sdbuf_index = buf_off[soc_pkg::sec_aw-1:0];
    assign mmio_wdata = req.wdata[31:0];

    // ram port, second beat goes to the next word
    always_comb begin
        ram_port.index = (state == st_second) ? word_idx + 1'b1 : word_idx;
        ram_port.we = !is_read && region == soc_pkg::ram && state != st_idle;
        case (req.ls_type)
            soc_pkg::lb: begin
                // sb, byte copied to every lane
                ram_port.be = 4'b0001 << offset;
                ram_port.wdata = {4{req.wdata[7:0]}};
            end
            soc_pkg::lh: begin
                ram_port.be = offset[1] ? 4'b1100 : 4'b0011;
                ram_port.wdata = {2{req.wdata[15:0]}};
            end
            default: begin
                // sw, or one half of sd
                ram_port.be = 4'b1111;
                ram_port.wdata = (state == st_second) ? req.wdata[63:32] : req.wdata[31:0];
            end
        endcase
    end

    // read source per region
    always_comb begin
        case (region)
            soc_pkg::ram: src_data = {32'd0, ram_rdata} >> {offset, 3'b000};
            soc_pkg::key: src_data = {56'd0, key_code};
            soc_pkg::sdc_ready: src_data = {63'd0, sd_ready};
            soc_pkg::sdc_avail: src_data = {63'd0, sdbuf_avail};
            soc_pkg::sdc_buf: src_data = {56'd0, sdbuf_byte};
            default: src_data = '0;
        endcase
    end

    // register strobes land in the finish cycle
    assign sdc_addr_we = finish && !is_read && region == soc_pkg::sdc_addr;
    assign sdc_read_we = finish && !is_read && region == soc_pkg::sdc_read;
    assign uart_we = finish && !is_read && region == soc_pkg::uart;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= st_idle;
            is_read <= 1'b0;
            finish <= 1'b0;
            read_done <= 1'b1;
            write_done <= 1'b1;
            read_data <= '0;
        end else begin
            finish <= 1'b0;
            case (state)
                st_idle: begin
                    if (read_en || write_en) begin
                        state <= st_first;
                        is_read <= read_en;
                    end
                    if (read_en) begin
                        read_done <= 1'b0;
                    end
                    if (write_en) begin
                        write_done <= 1'b0;
                    end
                end
                st_first: begin
                    // only ld and sd to ram need a second beat
                    if (region == soc_pkg::ram && is_double) begin
                        state <= st_second;
                    end else begin
                        state <= st_idle;
                        finish <= 1'b1;
                    end
                end
                st_second: begin
                    // low word arrives here
                    if (is_read) begin
                        read_data <= {32'd0, ram_rdata};
                    end
                    state <= st_idle;
                    finish <= 1'b1;
                end
                default: state <= st_idle;
            endcase
            if (finish) begin
                read_done <= 1'b1;
                write_done <= 1'b1;
                if (is_read) begin
                    if (region == soc_pkg::ram && is_double) begin
                        read_data[63:32] <= ram_rdata;
                    end else begin
                        read_data <= src_data;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/soc_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input wire CLOCK_50,
    input wire KEY0,
    input wire soc_pkg::bus_req_t req,
    input wire read_en,
    input wire write_en,
    input wire irq_ack,
    output logic [soc_pkg::data_w-1:0] read_data,
    output logic read_done,
    output logic write_done,
    output logic [3:0] irq_vector,
    output logic irq_led,
    output logic [31:0] uart_data,
    output logic uart_write,
    output logic [31:0] sd_addr,
    output logic sd_rd_start,
    input wire [7:0] sd_dout,
    input wire sd_byte_available,
    input wire sd_ready,
    input wire [7:0] ascii,
    input wire key_pressed
);

    soc_pkg::ram_port_t ram_port;
    logic [31:0] ram_rdata;
    logic [soc_pkg::sec_aw-1:0] sdbuf_index;
    logic [7:0] sdbuf_byte;
    logic sdbuf_avail;
    logic [7:0] key_code;
    logic sdc_addr_we;
    logic sdc_read_we;
    logic uart_we;
    logic [31:0] mmio_wdata;

    // decode and sequencing
    bus_controller ctrl_i (
        .CLOCK_50(CLOCK_50),
        .KEY0(KEY0),
        .req(req),
        .read_en(read_en),
        .write_en(write_en),
        .read_data(read_data),
        .read_done(read_done),
        .write_done(write_done),
        .ram_port(ram_port),
        .ram_rdata(ram_rdata),
        .sdbuf_index(sdbuf_index),
        .sdbuf_byte(sdbuf_byte),
        .sdbuf_avail(sdbuf_avail),
        .key_code(key_code),
        .sd_ready(sd_ready),
        .sdc_addr_we(sdc_addr_we),
        .sdc_read_we(sdc_read_we),
        .uart_we(uart_we),
        .mmio_wdata(mmio_wdata)
    );

    word_ram ram_i (
        .CLOCK_50(CLOCK_50),
        .port(ram_port),
        .rdata(ram_rdata)
    );

    // sector bytes from the sd controller
    sd_sector_buffer sdbuf_i (
        .CLOCK_50(CLOCK_50),
        .KEY0(KEY0),
        .sd_dout(sd_dout),
        .sd_byte_available(sd_byte_available),
        .index(sdbuf_index),
        .byte_out(sdbuf_byte),
        .available(sdbuf_avail)
    );

    key_irq key_i (
        .CLOCK_50(CLOCK_50),
        .KEY0(KEY0),
        .ascii(ascii),
        .key_pressed(key_pressed),
        .irq_ack(irq_ack),
        .key_code(key_code),
        .irq_vector(irq_vector),
        .irq_led(irq_led)
    );

    // sd address, read start, console
    mmio_regs mmio_i (
        .CLOCK_50(CLOCK_50),
        .KEY0(KEY0),
        .sdc_addr_we(sdc_addr_we),
        .sdc_read_we(sdc_read_we),
        .uart_we(uart_we),
        .wdata(mmio_wdata),
        .sd_addr(sd_addr),
        .sd_rd_start(sd_rd_start),
        .uart_data(uart_data),
        .uart_write(uart_write)
    );

endmodule

`default_nettype wire

/* verif/soc_bus_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_asserts (
    input wire CLOCK_50,
    input wire KEY0,
    input wire soc_pkg::bus_req_t req,
    input wire read_en,
    input wire write_en,
    input wire read_done,
    input wire write_done,
    input wire uart_write,
    input wire sd_rd_start,
    input wire irq_ack,
    input wire [3:0] irq_vector
);

    // failure count, polled from the testbench top
    int unsigned fails = 0;
    logic long_access;

    // ld and sd to ram take a second beat
    assign long_access = req.ls_type == soc_pkg::ld &&
        req.address >= soc_pkg::ram_base &&
        req.address < soc_pkg::ram_base + 64'(4 * soc_pkg::ram_words);

    // done low the cycle after the strobe, high again 2 or 3 cycles on
    a_read_short: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        read_en && !long_access |=> !read_done ##1 !read_done ##1 read_done)
    else begin
        fails++;
        $error("single-beat read done timing wrong");
    end

    a_read_long: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        read_en && long_access |=> !read_done ##1 !read_done ##1 !read_done ##1 read_done)
    else begin
        fails++;
        $error("double read done timing wrong");
    end

    a_write_short: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        write_en && !long_access |=> !write_done ##1 !write_done ##1 write_done)
    else begin
        fails++;
        $error("single-beat write done timing wrong");
    end

    a_write_long: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        write_en && long_access |=> !write_done ##1 !write_done ##1 !write_done ##1 write_done)
    else begin
        fails++;
        $error("double write done timing wrong");
    end

    // single-cycle pulses
    a_uart_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write |=> !uart_write)
    else begin
        fails++;
        $error("uart_write longer than one cycle");
    end

    a_sd_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start)
    else begin
        fails++;
        $error("sd_rd_start longer than one cycle");
    end

    // ack clears a pending request
    a_irq_ack: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_ack && irq_vector != 4'd0 |=> irq_vector == 4'd0)
    else begin
        fails++;
        $error("irq_vector not cleared after ack");
    end

endmodule

bind soc_bus_top soc_bus_asserts asserts_i (
    .CLOCK_50(CLOCK_50),
    .KEY0(KEY0),
    .req(req),
    .read_en(read_en),
    .write_en(write_en),
    .read_done(read_done),
    .write_done(write_done),
    .uart_write(uart_write),
    .sd_rd_start(sd_rd_start),
    .irq_ack(irq_ack),
    .irq_vector(irq_vector)
);

`default_nettype wire

/* verif/tb_soc_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

    // access counts per test
    localparam int n_rand = 16;
    localparam int n_double = 8;
    localparam int n_window = 32;
    // 12 per store round, 2 per double, 3 mmio writes, 4 status reads, key read
    localparam int num_accesses = n_rand * 12 + n_double * 2 + 3 + 4 + n_window + 1;
    // 4 cycles per sector byte, plus reset and irq slack
    localparam int watchdog_cycles = num_accesses * 10 + soc_pkg::sector_bytes * 4 + 64;

    logic CLOCK_50;
    logic KEY0;
    soc_pkg::bus_req_t req;
    logic read_en;
    logic write_en;
    logic irq_ack;
    logic [63:0] read_data;
    logic read_done;
    logic write_done;
    logic [3:0] irq_vector;
    logic irq_led;
    logic [31:0] uart_data;
    logic uart_write;
    logic [31:0] sd_addr;
    logic sd_rd_start;
    logic [7:0] sd_dout;
    logic sd_byte_available;
    logic sd_ready;
    logic [7:0] ascii;
    logic key_pressed;

    // reference copies of ram words and sector bytes
    logic [31:0] model [soc_pkg::ram_words];
    logic [7:0] sector [soc_pkg::sector_bytes];
    logic [31:0] lfsr = 32'h2952_6ed6;

    soc_bus_top dut_i (
        .CLOCK_50(CLOCK_50),
        .KEY0(KEY0),
        .req(req),
        .read_en(read_en),
        .write_en(write_en),
        .irq_ack(irq_ack),
        .read_data(read_data),
        .read_done(read_done),
        .write_done(write_done),
        .irq_vector(irq_vector),
        .irq_led(irq_led),
        .uart_data(uart_data),
        .uart_write(uart_write),
        .sd_addr(sd_addr),
        .sd_rd_start(sd_rd_start),
        .sd_dout(sd_dout),
        .sd_byte_available(sd_byte_available),
        .sd_ready(sd_ready),
        .ascii(ascii),
        .key_pressed(key_pressed)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic fb;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic logic [63:0] word_addr(input int idx, input int off);
        return soc_pkg::ram_base + 64'(4 * idx + off);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic expect_value(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
        assert (got === exp)
        else report_mismatch($sformatf("%s gave %h, expected %h", what, got, exp));
    endtask

    // back to 5 ns after a rising edge
    task automatic next_cycle(input int n);
        repeat (n) @(posedge CLOCK_50);
        #5;
    endtask

    // one strobe, then wait for the matching done level
    task automatic bus_access(input logic wr, input logic [63:0] addr,
                              input logic [63:0] wdata, input soc_pkg::ls_type_e ls,
                              input int exp_cycles, output logic [63:0] rdata);
        int cycles;
        req.address = addr;
        req.wdata = wdata;
        req.ls_type = ls;
        read_en = !wr;
        write_en = wr;
        next_cycle(1);
        read_en = 1'b0;
        write_en = 1'b0;
        cycles = 0;
        do begin
            next_cycle(1);
            cycles++;
        end while (!(wr ? write_done : read_done));
        rdata = read_data;
        expect_value(64'(cycles), 64'(exp_cycles), "cycles to done");
    endtask

    // lw, lhu and lbu of one word against the model
    task automatic check_word(input int idx, input int off);
        logic [63:0] got;
        bus_access(1'b0, word_addr(idx, 0), '0, soc_pkg::lw, 2, got);
        expect_value(got, {32'd0, model[idx]}, "lw");
        bus_access(1'b0, word_addr(idx, off & 2), '0, soc_pkg::lhu, 2, got);
        expect_value(got, {32'd0, model[idx]} >> (8 * (off & 2)), "lhu");
        bus_access(1'b0, word_addr(idx, off), '0, soc_pkg::lbu, 2, got);
        expect_value(got, {32'd0, model[idx]} >> (8 * off), "lbu");
    endtask

    // bound checker failures end the run at once
    always @(negedge CLOCK_50) begin
        if (dut_i.asserts_i.fails != 0) begin
            $display("bus timing assertion failed at %0t ns", $time);
            $display("Done: errors found");
            $fatal(1, "stopping at first error");
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge CLOCK_50);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $fatal(1, "run timed out");
    end

    initial begin
        logic [63:0] got;
        logic [63:0] value;
        int idx;
        int off;
        int n;
        KEY0 = 1'b0;
        req = '0;
        read_en = 1'b0;
        write_en = 1'b0;
        irq_ack = 1'b0;
        sd_dout = 8'd0;
        sd_byte_available = 1'b0;
        sd_ready = 1'b0;
        ascii = 8'd0;
        key_pressed = 1'b0;
        next_cycle(4);
        KEY0 = 1'b1;
        next_cycle(1);

        // sw then sh then sb into the same word
        for (n = 0; n < n_rand; n++) begin
            idx = int'(rand_bits(10));
            value = rand_bits(32);
            bus_access(1'b1, word_addr(idx, 0), value, soc_pkg::lw, 2, got);
            model[idx] = value[31:0];
            check_word(idx, 0);
            off = int'(rand_bits(1)) * 2;
            value = rand_bits(16);
            bus_access(1'b1, word_addr(idx, off), value, soc_pkg::lh, 2, got);
            model[idx][8*off +: 16] = value[15:0];
            check_word(idx, off);
            off = int'(rand_bits(2));
            value = rand_bits(8);
            bus_access(1'b1, word_addr(idx, off), value, soc_pkg::lb, 2, got);
            model[idx][8*off +: 8] = value[7:0];
            check_word(idx, off);
        end

        // sd and ld, even index so the pair stays inside ram
        for (n = 0; n < n_double; n++) begin
            idx = int'(rand_bits(9)) * 2;
            value = rand_bits(64);
            bus_access(1'b1, word_addr(idx, 0), value, soc_pkg::ld, 3, got);
            bus_access(1'b0, word_addr(idx, 0), '0, soc_pkg::ld, 3, got);
            expect_value(got, value, "ld");
        end

        // console write, one pulse with the low half
        value = rand_bits(64);
        bus_access(1'b1, soc_pkg::uart_addr, value, soc_pkg::lw, 2, got);
        expect_value({63'd0, uart_write}, 64'd1, "uart_write");
        expect_value({32'd0, uart_data}, {32'd0, value[31:0]}, "uart_data");
        next_cycle(1);
        expect_value({63'd0, uart_write}, 64'd0, "uart_write after pulse");
        value = rand_bits(32);
        bus_access(1'b1, soc_pkg::sdc_addr_addr, value, soc_pkg::lw, 2, got);
        expect_value({32'd0, sd_addr}, value, "sd_addr");
        bus_access(1'b1, soc_pkg::sdc_read_addr, '0, soc_pkg::lw, 2, got);
        expect_value({63'd0, sd_rd_start}, 64'd1, "sd_rd_start");
        next_cycle(1);
        expect_value({63'd0, sd_rd_start}, 64'd0, "sd_rd_start after pulse");

        // no sector yet
        bus_access(1'b0, soc_pkg::sdc_avail_addr, '0, soc_pkg::lw, 2, got);
        expect_value(got, 64'd0, "sector available before fill");

        // one full sector, strobe high 2 cycles and low 2
        for (n = 0; n < soc_pkg::sector_bytes; n++) begin
            value = rand_bits(8);
            sector[n] = value[7:0];
            sd_dout = value[7:0];
            sd_byte_available = 1'b1;
            next_cycle(2);
            sd_byte_available = 1'b0;
            next_cycle(2);
        end
        bus_access(1'b0, soc_pkg::sdc_avail_addr, '0, soc_pkg::lw, 2, got);
        expect_value(got, 64'd1, "sector available");
        sd_ready = 1'b1;
        bus_access(1'b0, soc_pkg::sdc_ready_addr, '0, soc_pkg::lw, 2, got);
        expect_value(got, 64'd1, "sd ready high");
        sd_ready = 1'b0;
        bus_access(1'b0, soc_pkg::sdc_ready_addr, '0, soc_pkg::lw, 2, got);
        expect_value(got, 64'd0, "sd ready low");
        for (n = 0; n < n_window; n++) begin
            off = int'(rand_bits(9));
            bus_access(1'b0, soc_pkg::sdc_buf_base + 64'(off), '0, soc_pkg::lbu, 2, got);
            expect_value(got, {56'd0, sector[off]}, "sector byte");
        end

        // key press, nonzero code
        value = rand_bits(7) + 64'd1;
        ascii = value[7:0];
        key_pressed = 1'b1;
        next_cycle(1);
        expect_value({60'd0, irq_vector}, 64'd1, "irq_vector on press");
        expect_value({63'd0, irq_led}, 64'd1, "irq_led on press");
        key_pressed = 1'b0;
        bus_access(1'b0, soc_pkg::key_addr, '0, soc_pkg::lw, 2, got);
        expect_value(got, {56'd0, value[7:0]}, "key code");
        // request must outlive the key release
        expect_value({60'd0, irq_vector}, 64'd1, "irq_vector held before ack");
        expect_value({63'd0, irq_led}, 64'd1, "irq_led held before ack");
        irq_ack = 1'b1;
        next_cycle(1);
        irq_ack = 1'b0;
        expect_value({60'd0, irq_vector}, 64'd0, "irq_vector after ack");
        expect_value({63'd0, irq_led}, 64'd0, "irq_led after ack");
        next_cycle(2);

        if (dut_i.asserts_i.fails == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "bus timing assertions failed");
        end
    end

endmodule

`default_nettype wire

/* tb.f */
src/soc_pkg.sv
src/word_ram.sv
src/sd_sector_buffer.sv
src/key_irq.sv
src/mmio_regs.sv
src/bus_controller.sv
src/soc_bus_top.sv
verif/soc_bus_asserts.sv
verif/tb_soc_bus.sv

/* run.sh */
#!/bin/sh
# build and run the bus fabric testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_bus -f tb.f -o tb_soc_bus
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# assertion errors are counted by the testbench, so let the run continue past them
./obj_dir/tb_soc_bus +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi
exit 0
